//--- i2c_master.f
logic/i2c_pkg.sv
logic/i2c_scl_gen.sv
logic/i2c_sequencer.sv
logic/i2c_data_path.sv
logic/i2c_master_top.sv
verification/i2c_master_checker.sv
verification/i2c_master_tb.sv

//--- logic/i2c_data_path.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_data_path import i2c_pkg::*; #(
    parameter int DATA_BYTES = 4,
    localparam int IDX_W = $clog2(DATA_BYTES + 1)
) (
    input wire clk,
    input wire rst,
    input wire [ADDR_W-1:0] slave_addr,
    input wire rw,
    input wire [REG_ADDR_W-1:0] reg_addr,
    input wire [DATA_BYTES*BYTE_W-1:0] wdata,
    input wire cmd_load,
    input wire tx_load,
    input wire byte_src_t tx_src,
    input wire [IDX_W-1:0] byte_index,
    input wire tx_shift,
    input wire rx_shift,
    input wire rx_store,
    input wire sda_in,
    output logic tx_bit,
    output logic [DATA_BYTES*BYTE_W-1:0] rdata
);

    logic [ADDR_W-1:0] addr_q;
    logic [REG_ADDR_W-1:0] reg_q;
    logic [DATA_BYTES*BYTE_W-1:0] wdata_q;
    byte_t tx_q;
    byte_t rx_q;
    byte_t src_byte;

    always_ff @(posedge clk) begin
        if (cmd_load) begin
            addr_q <= slave_addr;
            reg_q <= reg_addr;
            wdata_q <= wdata;
        end
    end

    // Data bytes counted from the most significant end of wdata
    always_comb begin
        case (tx_src)
            ADDR_WRITE: src_byte = {addr_q, RW_WRITE};
            ADDR_READ: src_byte = {addr_q, RW_READ};
            REG: src_byte = reg_q;
            default: src_byte = wdata_q[(DATA_BYTES - int'(byte_index)) * BYTE_W - 1 -: BYTE_W];
        endcase
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_q <= src_byte;
        end else if (tx_shift) begin
            tx_q <= {tx_q[BYTE_W-2:0], 1'b0};
        end
        if (rx_shift) begin
            rx_q <= {rx_q[BYTE_W-2:0], sda_in};
        end
    end

    assign tx_bit = tx_q[BYTE_W-1];

    // Cleared when a read starts, so an aborted read leaves zeros behind
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (cmd_load && rw == RW_READ) begin
            rdata <= '0;
        end else if (rx_store) begin
            rdata[(DATA_BYTES - int'(byte_index)) * BYTE_W - 1 -: BYTE_W] <= rx_q;
        end
    end

    a_load_not_cmd: assert property (@(posedge clk) disable iff (rst)
        cmd_load |-> !tx_load);

endmodule

`default_nettype wire

//--- logic/i2c_master_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_top import i2c_pkg::*; #(
    parameter int DATA_BYTES = 4,
    parameter int SCL_QUARTER = 4,
    localparam int IDX_W = $clog2(DATA_BYTES + 1)
) (
    input wire clk,
    input wire rst,
    input wire start,
    input wire rw,
    input wire [ADDR_W-1:0] slave_addr,
    input wire [REG_ADDR_W-1:0] reg_addr,
    input wire [DATA_BYTES*BYTE_W-1:0] wdata,
    output logic busy,
    output logic done,
    output logic nack,
    output logic [DATA_BYTES*BYTE_W-1:0] rdata,
    output logic scl,
    output logic sda_out,
    input wire sda_in
);

    logic run;
    logic [1:0] quarter;
    logic quarter_tick;
    logic bit_done;
    logic cmd_load;
    logic tx_load;
    byte_src_t tx_src;
    logic [IDX_W-1:0] byte_index;
    logic tx_shift;
    logic rx_shift;
    logic rx_store;
    logic tx_bit;

    i2c_scl_gen #(
        .SCL_QUARTER(SCL_QUARTER)
    ) u_scl_gen (
        .clk(clk),
        .rst(rst),
        .run(run),
        .scl(scl),
        .quarter(quarter),
        .quarter_tick(quarter_tick),
        .bit_done(bit_done)
    );

    i2c_sequencer #(
        .DATA_BYTES(DATA_BYTES)
    ) u_sequencer (
        .clk(clk),
        .rst(rst),
        .start(start),
        .rw(rw),
        .quarter(quarter),
        .quarter_tick(quarter_tick),
        .bit_done(bit_done),
        .sda_in(sda_in),
        .tx_bit(tx_bit),
        .run(run),
        .sda_out(sda_out),
        .cmd_load(cmd_load),
        .tx_load(tx_load),
        .tx_src(tx_src),
        .byte_index(byte_index),
        .tx_shift(tx_shift),
        .rx_shift(rx_shift),
        .rx_store(rx_store),
        .busy(busy),
        .done(done),
        .nack(nack)
    );

    i2c_data_path #(
        .DATA_BYTES(DATA_BYTES)
    ) u_data_path (
        .clk(clk),
        .rst(rst),
        .slave_addr(slave_addr),
        .rw(rw),
        .reg_addr(reg_addr),
        .wdata(wdata),
        .cmd_load(cmd_load),
        .tx_load(tx_load),
        .tx_src(tx_src),
        .byte_index(byte_index),
        .tx_shift(tx_shift),
        .rx_shift(rx_shift),
        .rx_store(rx_store),
        .sda_in(sda_in),
        .tx_bit(tx_bit),
        .rdata(rdata)
    );

endmodule

`default_nettype wire

//--- logic/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // Bus field widths
    localparam int ADDR_W = 7;
    localparam int BYTE_W = 8;
    localparam int REG_ADDR_W = 8;

    // Direction bit appended to the slave address
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ = 1'b1;

    typedef logic [BYTE_W-1:0] byte_t;

    // Byte states span nine bit slots, the last one is the acknowledge
    typedef enum logic [2:0] {
        IDLE, START, ADDR_BYTE, REG_BYTE, RESTART, DATA_BYTE, STOP
    } state_t;

    // Source of the next byte loaded into the transmitter
    typedef enum logic [1:0] {
        ADDR_WRITE, ADDR_READ, REG, DATA
    } byte_src_t;

endpackage

`default_nettype wire

//--- logic/i2c_scl_gen.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_scl_gen #(
    parameter int SCL_QUARTER = 4,
    localparam int CNT_W = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1
) (
    input wire clk,
    input wire rst,
    input wire run,
    output logic scl,
    output logic [1:0] quarter,
    output logic quarter_tick,
    output logic bit_done
);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_QUARTER - 1);

    logic [CNT_W-1:0] cnt;
    logic quarter_end;

    assign quarter_end = cnt == CNT_LAST;

    // Divider restarts from quarter 0 whenever the sequencer stops it
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            cnt <= '0;
            quarter <= 2'd0;
        end else if (quarter_end) begin
            cnt <= '0;
            quarter <= quarter + 2'd1;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    // Low in quarters 0 and 1, high in 2 and 3, high when idle
    always_ff @(posedge clk) begin
        if (rst) begin
            scl <= 1'b1;
        end else begin
            scl <= !run || quarter[1];
        end
    end

    assign quarter_tick = run && cnt == '0;
    assign bit_done = run && quarter_end && quarter == 2'd3;

    // Quarter 3 runs its full length before the slot closes
    a_bit_done_q3: assert property (@(posedge clk) disable iff (rst)
        (quarter_tick && quarter == 2'd3) |-> ##(SCL_QUARTER - 1) bit_done);

endmodule

`default_nettype wire

//--- logic/i2c_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_sequencer import i2c_pkg::*; #(
    parameter int DATA_BYTES = 4,
    localparam int IDX_W = $clog2(DATA_BYTES + 1)
) (
    input wire clk,
    input wire rst,
    input wire start,
    input wire rw,
    input wire [1:0] quarter,
    input wire quarter_tick,
    input wire bit_done,
    input wire sda_in,
    input wire tx_bit,
    output logic run,
    output logic sda_out,
    output logic cmd_load,
    output logic tx_load,
    output byte_src_t tx_src,
    output logic [IDX_W-1:0] byte_index,
    output logic tx_shift,
    output logic rx_shift,
    output logic rx_store,
    output logic busy,
    output logic done,
    output logic nack
);

    state_t state;
    state_t state_next;
    logic rw_q;
    logic second_addr;
    logic [3:0] bit_cnt;
    logic sda_smp;
    logic accept;
    logic q0_tick;
    logic q3_tick;
    logic in_byte;
    logic ack_slot;
    logic byte_end;
    logic reading;
    logic ack_bit;

    assign accept = start && !busy;
    assign run = accept || busy;
    assign cmd_load = accept;
    assign q0_tick = quarter_tick && quarter == 2'd0;
    assign q3_tick = quarter_tick && quarter == 2'd3;
    assign in_byte = state inside {ADDR_BYTE, REG_BYTE, DATA_BYTE};
    assign ack_slot = bit_cnt == 4'd8;
    assign byte_end = bit_done && ack_slot;
    // Master only receives in the data bytes of a read
    assign reading = state == DATA_BYTE && rw_q == RW_READ;
    // Live pin when the sample tick is also the last cycle of the slot
    assign ack_bit = quarter_tick ? sda_in : sda_smp;

    assign tx_shift = q0_tick && in_byte && !ack_slot && !reading;
    assign rx_shift = q3_tick && reading && !ack_slot;
    assign rx_store = q0_tick && reading && ack_slot;

    always_comb begin
        state_next = state;
        tx_load = 1'b0;
        tx_src = DATA;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = START;
                end
            end
            START, RESTART: begin
                if (bit_done) begin
                    state_next = ADDR_BYTE;
                    tx_load = 1'b1;
                    tx_src = (state == START) ? ADDR_WRITE : ADDR_READ;
                end
            end
            ADDR_BYTE: begin
                if (byte_end) begin
                    if (ack_bit) begin
                        state_next = STOP;
                    end else if (second_addr) begin
                        state_next = DATA_BYTE;
                    end else begin
                        state_next = REG_BYTE;
                        tx_load = 1'b1;
                        tx_src = REG;
                    end
                end
            end
            REG_BYTE: begin
                if (byte_end) begin
                    if (ack_bit) begin
                        state_next = STOP;
                    end else if (rw_q == RW_READ) begin
                        state_next = RESTART;
                    end else begin
                        state_next = DATA_BYTE;
                        tx_load = 1'b1;
                    end
                end
            end
            DATA_BYTE: begin
                // byte_index already points past the byte just finished
                if (byte_end) begin
                    if (byte_index == IDX_W'(DATA_BYTES) || (!reading && ack_bit)) begin
                        state_next = STOP;
                    end else begin
                        tx_load = !reading;
                    end
                end
            end
            STOP: begin
                if (bit_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (q3_tick) begin
            sda_smp <= sda_in;
        end
    end

    // Bit counter runs 0 to 8 inside a byte, byte counter over data bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= 4'd0;
            byte_index <= '0;
        end else begin
            if (bit_done) begin
                bit_cnt <= (in_byte && !ack_slot) ? bit_cnt + 4'd1 : 4'd0;
            end
            if (accept) begin
                byte_index <= '0;
            end else if (q0_tick && ack_slot && state == DATA_BYTE) begin
                byte_index <= byte_index + IDX_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            nack <= 1'b0;
            rw_q <= RW_WRITE;
            second_addr <= 1'b0;
            sda_out <= 1'b1;
        end else begin
            state <= state_next;
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                nack <= 1'b0;
                rw_q <= rw;
                second_addr <= 1'b0;
            end
            if (state == STOP && bit_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (state == RESTART && bit_done) begin
                second_addr <= 1'b1;
            end
            if (in_byte && byte_end && !reading && ack_bit) begin
                nack <= 1'b1;
            end
            if (q0_tick) begin
                if (state == STOP) begin
                    sda_out <= 1'b0;
                end else if (!in_byte) begin
                    sda_out <= 1'b1;
                end else if (!ack_slot) begin
                    sda_out <= reading ? 1'b1 : tx_bit;
                end else begin
                    // Released for the slave's acknowledge
                    // When reading, the master ACKs each byte but NACKs the last
                    sda_out <= !reading || byte_index == IDX_W'(DATA_BYTES - 1);
                end
            end else if (q3_tick) begin
                if (state == START || state == RESTART) begin
                    sda_out <= 1'b0;
                end else if (state == STOP) begin
                    sda_out <= 1'b1;
                end
            end
        end
    end

    // done marks the cycle busy drops
    a_done_ends_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy && $past(busy));

    a_load_not_shift: assert property (@(posedge clk) disable iff (rst)
        !(tx_load && tx_shift));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f i2c_master.f \
    --top-module i2c_master_tb -o i2c_master_sim &&
out="$(./obj_dir/i2c_master_sim)" || exit 1
echo "$out"
echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$' && exit 0 || exit 1

//--- verification/i2c_master_checker.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_checker #(
    parameter int DATA_BYTES = 4,
    parameter int SCL_QUARTER = 4
) (
    input wire clk,
    input wire rst,
    input wire scl,
    input wire sda,
    input wire sda_out,
    input wire start,
    input wire busy,
    input wire done,
    input wire nack,
    input wire [DATA_BYTES*8-1:0] rdata,
    input wire exp_rw,
    input wire [6:0] exp_addr,
    input wire [7:0] exp_reg,
    input wire [DATA_BYTES*8-1:0] exp_data,
    input wire [7:0] exp_nack_at,
    output int errors
);

    // Bus tokens: {byte, ack} for a byte, or a bus condition
    localparam logic [11:0] TOK_START = 12'h400;
    localparam logic [11:0] TOK_STOP = 12'h800;
    localparam int T = 4 * SCL_QUARTER;

    logic [11:0] obs_q[$];
    logic [11:0] exp_q[$];
    logic prev_scl;
    logic prev_sda;
    logic [8:0] shreg;
    int bit_cnt;
    int cycle;
    int t_acc;
    logic in_cmd;
    logic seen_cmd;

    task automatic push_byte(input logic [7:0] b, input logic ack, inout logic abort);
        if (!abort) begin
            exp_q.push_back({3'b000, b, ack});
            abort = ack;
        end
    endtask

    task automatic build_expected();
        logic abort;
        abort = 1'b0;
        exp_q.delete();
        exp_q.push_back(TOK_START);
        push_byte({exp_addr, 1'b0}, exp_nack_at == 8'd1, abort);
        push_byte(exp_reg, exp_nack_at == 8'd2, abort);
        for (int k = 0; k < DATA_BYTES; k++) begin
            if (!exp_rw) begin
                push_byte(exp_data[(DATA_BYTES-1-k)*8 +: 8], exp_nack_at == 8'(4 + k), abort);
            end
        end
        if (exp_rw && !abort) begin
            exp_q.push_back(TOK_START);
            push_byte({exp_addr, 1'b1}, exp_nack_at == 8'd3, abort);
            // Master NACKs only the last byte it reads
            for (int k = 0; k < DATA_BYTES; k++) begin
                push_byte(exp_data[(DATA_BYTES-1-k)*8 +: 8], k == DATA_BYTES - 1, abort);
            end
        end
        exp_q.push_back(TOK_STOP);
    endtask

    task automatic check_command();
        logic [DATA_BYTES*8-1:0] exp_rdata;
        int exp_lat;
        build_expected();
        if (obs_q.size() != exp_q.size()) begin
            $display("[ERROR] %0t bus token count: got %0d expected %0d",
                $time, obs_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < obs_q.size() && i < exp_q.size(); i++) begin
            if (obs_q[i] !== exp_q[i]) begin
                $display("[ERROR] %0t bus token %0d: got %h expected %h",
                    $time, i, obs_q[i], exp_q[i]);
                errors++;
            end
        end
        if (nack !== (exp_nack_at != 8'd0)) begin
            $display("[ERROR] %0t nack: got %b expected %b", $time, nack, exp_nack_at != 8'd0);
            errors++;
        end
        exp_rdata = (exp_nack_at == 8'd0) ? exp_data : '0;
        if (exp_rw && rdata !== exp_rdata) begin
            $display("[ERROR] %0t rdata: got %h expected %h", $time, rdata, exp_rdata);
            errors++;
        end
        exp_lat = exp_rw ? (3 + 9 * (3 + DATA_BYTES)) * T : (2 + 9 * (2 + DATA_BYTES)) * T;
        if (exp_nack_at == 8'd0 && cycle - t_acc != exp_lat) begin
            $display("[ERROR] %0t latency: got %0d expected %0d", $time, cycle - t_acc, exp_lat);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            prev_scl = 1'b1;
            prev_sda = 1'b1;
            bit_cnt = 0;
            cycle = 0;
            in_cmd = 1'b0;
            seen_cmd = 1'b0;
            errors = 0;
        end else begin
            cycle++;
            if (!in_cmd && start && !busy) begin
                in_cmd = 1'b1;
                seen_cmd = 1'b1;
                t_acc = cycle;
                obs_q.delete();
            end else if (in_cmd && done) begin
                in_cmd = 1'b0;
                check_command();
            end else if (in_cmd && !busy) begin
                $display("[ERROR] %0t busy: got 0 expected 1", $time);
                errors++;
            end else if (!in_cmd) begin
                if (scl !== 1'b1 || sda_out !== 1'b1 || busy !== 1'b0 || done !== 1'b0 ||
                    (!seen_cmd && nack !== 1'b0)) begin
                    $display("[ERROR] %0t idle scl/sda_out/busy/done/nack: got %b%b%b%b%b expected 11000",
                        $time, scl, sda_out, busy, done, nack);
                    errors++;
                end
            end
            // Conditions need SCL high in both samples
            if (scl && prev_scl && prev_sda && !sda) begin
                obs_q.push_back(TOK_START);
                bit_cnt = 0;
            end else if (scl && prev_scl && !prev_sda && sda) begin
                obs_q.push_back(TOK_STOP);
                bit_cnt = 0;
            end else if (scl && !prev_scl) begin
                shreg = {shreg[7:0], sda};
                bit_cnt++;
                if (bit_cnt == 9) begin
                    obs_q.push_back({3'b000, shreg});
                    bit_cnt = 0;
                end
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

`default_nettype wire

//--- verification/i2c_master_stim.txt
// Per command: rw slave_addr reg_addr data nack_at
// nack_at 0 none, 1 write addr, 2 reg addr, 3 read addr, 4+k data byte k
0 50 10 deadbeef 0
1 50 10 a5c3193e 0
0 3a 7f 01020304 0
1 3a 20 80ff0055 0
0 12 05 11223344 1
0 12 06 55667788 2
0 12 07 99aabbcc 5
1 44 30 cafef00d 3
1 44 31 12345678 1
0 68 00 0badf00d 7

//--- verification/i2c_master_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_tb;

    localparam int DATA_BYTES = 4;
    localparam int SCL_QUARTER = 4;
    localparam int NUM_CMDS = 10;
    localparam int FIELDS = 5;
    localparam int SEED = 84352;
    localparam int READ_CYCLES = (3 + 9 * (3 + DATA_BYTES)) * 4 * SCL_QUARTER;
    localparam longint LIMIT_NS = (longint'(NUM_CMDS) * READ_CYCLES * 2 + 1000) * 100;

    logic clk;
    logic rst;
    logic start;
    logic rw;
    logic [6:0] slave_addr;
    logic [7:0] reg_addr;
    logic [DATA_BYTES*8-1:0] wdata;
    logic busy;
    logic done;
    logic nack;
    logic [DATA_BYTES*8-1:0] rdata;
    logic scl;
    logic sda_out;
    logic slave_sda;
    wire sda_bus;
    logic [31:0] stim[0:NUM_CMDS*FIELDS-1];
    logic cur_rw;
    logic [6:0] cur_addr;
    logic [7:0] cur_reg;
    logic [DATA_BYTES*8-1:0] cur_data;
    logic [7:0] cur_nack_at;
    int errors;

    // Slave model state
    logic s_scl;
    logic s_sda;
    logic active;
    logic seg;
    logic quiet;
    int rises;

    // Open-drain bus shared by master and slave
    assign sda_bus = sda_out & slave_sda;

    i2c_master_top #(
        .DATA_BYTES(DATA_BYTES),
        .SCL_QUARTER(SCL_QUARTER)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .rw(rw),
        .slave_addr(slave_addr),
        .reg_addr(reg_addr),
        .wdata(wdata),
        .busy(busy),
        .done(done),
        .nack(nack),
        .rdata(rdata),
        .scl(scl),
        .sda_out(sda_out),
        .sda_in(sda_bus)
    );

    i2c_master_checker #(
        .DATA_BYTES(DATA_BYTES),
        .SCL_QUARTER(SCL_QUARTER)
    ) u_checker (
        .clk(clk),
        .rst(rst),
        .scl(scl),
        .sda(sda_bus),
        .sda_out(sda_out),
        .start(start),
        .busy(busy),
        .done(done),
        .nack(nack),
        .rdata(rdata),
        .exp_rw(cur_rw),
        .exp_addr(cur_addr),
        .exp_reg(cur_reg),
        .exp_data(cur_data),
        .exp_nack_at(cur_nack_at),
        .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Slave: ACKs sent bytes, returns read data, NACKs the chosen byte
    always @(negedge clk) begin
        int b;
        int bit_pos;
        int code;
        if (rst) begin
            slave_sda = 1'b1;
            s_scl = 1'b1;
            s_sda = 1'b1;
            active = 1'b0;
            seg = 1'b0;
            quiet = 1'b0;
            rises = 0;
        end else begin
            if (scl && s_scl && s_sda && !sda_bus) begin
                seg = active;
                active = 1'b1;
                quiet = 1'b0;
                rises = 0;
            end else if (scl && s_scl && !s_sda && sda_bus) begin
                active = 1'b0;
            end else if (scl && !s_scl) begin
                rises++;
            end else if (!scl && s_scl) begin
                b = rises / 9;
                bit_pos = rises % 9;
                slave_sda = 1'b1;
                if (active && !quiet && bit_pos == 8 && (!seg || b == 0)) begin
                    code = seg ? 3 : (b < 2 ? b + 1 : b + 2);
                    slave_sda = (code == int'(cur_nack_at));
                    quiet = slave_sda;
                end else if (active && !quiet && seg && b >= 1 && b <= DATA_BYTES &&
                             bit_pos < 8) begin
                    slave_sda = cur_data[(DATA_BYTES - b) * 8 + 7 - bit_pos];
                end
            end
            s_scl = scl;
            s_sda = sda_bus;
        end
    end

    initial begin
        int gap;
        rst = 1'b1;
        start = 1'b0;
        rw = 1'b0;
        slave_addr = '0;
        reg_addr = '0;
        wdata = '0;
        cur_rw = 1'b0;
        cur_addr = '0;
        cur_reg = '0;
        cur_data = '0;
        cur_nack_at = '0;
        void'($urandom(SEED));
        $readmemh("verification/i2c_master_stim.txt", stim);
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);
        for (int i = 0; i < NUM_CMDS; i++) begin
            gap = $urandom % 21;
            repeat (gap) @(negedge clk);
            cur_rw = stim[i*FIELDS][0];
            cur_addr = stim[i*FIELDS+1][6:0];
            cur_reg = stim[i*FIELDS+2][7:0];
            cur_data = stim[i*FIELDS+3];
            cur_nack_at = stim[i*FIELDS+4][7:0];
            rw = cur_rw;
            slave_addr = cur_addr;
            reg_addr = cur_reg;
            wdata = cur_data;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            // Stray command while busy must be ignored
            repeat (50) @(negedge clk);
            rw = ~cur_rw;
            slave_addr = ~cur_addr;
            wdata = ~cur_data;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            while (!done) @(negedge clk);
            // Checker compares at the edge that closes the done cycle
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        $display("Errors: %0d mismatches, 0 timeouts", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS * 1ns);
        $display("Errors: %0d mismatches, 1 timeout", errors);
        $display("Timeout: the DUT did not finish all commands in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
